// ==== hdl/vga_cfg.svh ====
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// 640x480 at 60 Hz, about a 25 MHz pixel clock
`define VGA_H640_SYNC    96
`define VGA_H640_BACK    48
`define VGA_H640_DISP    640
`define VGA_H640_TOTAL   800

`define VGA_V480_SYNC    2
`define VGA_V480_BACK    33
`define VGA_V480_DISP    480
`define VGA_V480_TOTAL   525

// 1024x768 at 60 Hz, about a 65 MHz pixel clock
`define VGA_H1024_SYNC   136
`define VGA_H1024_BACK   160
`define VGA_H1024_DISP   1024
`define VGA_H1024_TOTAL  1344   // needs all 11 counter bits

`define VGA_V768_SYNC    6
`define VGA_V768_BACK    29
`define VGA_V768_DISP    768
`define VGA_V768_TOTAL   806

// pixels per line buffer, covers the widest mode
`define VGA_LINE_DEPTH   1024

`endif

// ==== hdl/vga_timing_pkg.sv ====
`default_nettype none

package vga_timing_pkg;

    // horizontal or vertical position, up to 1344
    typedef logic [10:0] vga_count_t;

    // display mode, picked by a level input
    typedef enum logic {
        res_640x480  = 1'b0,
        res_1024x768 = 1'b1
    } vga_res_t;

endpackage

`default_nettype wire

// ==== hdl/vga_pixel_pkg.sv ====
`default_nettype none

package vga_pixel_pkg;

    typedef logic [15:0] pixel_t;      // rgb565
    typedef logic [9:0]  col_addr_t;   // column inside a line buffer
    typedef logic [15:0] line_addr_t;  // line number in the external store

endpackage

`default_nettype wire

// ==== hdl/vga_line_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface vga_line_if;

    vga_pixel_pkg::col_addr_t col;      // column being scanned
    vga_pixel_pkg::pixel_t    pixel_a;  // buffer a at col
    vga_pixel_pkg::pixel_t    pixel_b;  // buffer b at col
    logic                     rd_sel;   // 1 shows buffer b

    // timer side, picks the buffer and the column
    modport scan (
        output col,
        output rd_sel,
        input  pixel_a,
        input  pixel_b
    );

    // both buffers answer the same column, no handshake
    modport buffer (
        input  col,
        output pixel_a,
        output pixel_b
    );

endinterface

`default_nettype wire

// ==== hdl/vga_line_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vga_cfg.svh"

module vga_line_buffer (
    input  wire                             vga_clk,
    input  wire                             wr_en,
    input  wire                             wr_sel,
    input  wire vga_pixel_pkg::col_addr_t   wr_col,
    input  wire vga_pixel_pkg::pixel_t      wr_data,
    vga_line_if.buffer                      line
);

    // ping-pong pair, one displayed while the other fills
    vga_pixel_pkg::pixel_t mem_a [`VGA_LINE_DEPTH];
    vga_pixel_pkg::pixel_t mem_b [`VGA_LINE_DEPTH];

    logic we_a;
    logic we_b;

    assign we_a = wr_en && !wr_sel;
    assign we_b = wr_en && wr_sel;

    always_ff @(posedge vga_clk) begin
        if (we_a)
            mem_a[wr_col] <= wr_data;
    end

    always_ff @(posedge vga_clk) begin
        if (we_b)
            mem_b[wr_col] <= wr_data;
    end

    // read ports are async, data valid in the cycle of col
    assign line.pixel_a = mem_a[line.col];
    assign line.pixel_b = mem_b[line.col];

endmodule

`default_nettype wire

// ==== hdl/vga_scan_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vga_cfg.svh"

module vga_scan_timer (
    input  wire                       vga_clk,
    input  wire                       sys_rst_n,
    input  wire vga_timing_pkg::vga_res_t  res,
    input  wire vga_pixel_pkg::line_addr_t frame_base,
    input  wire                       mute,
    vga_line_if.scan                  line,
    output logic                      vga_hs,
    output logic                      vga_vs,
    output logic                      blanking,
    output logic                      line_req,
    output logic                      line_sel,
    output vga_pixel_pkg::line_addr_t line_addr,
    output vga_pixel_pkg::pixel_t     vga_rgb
);

    vga_timing_pkg::vga_res_t   res_q;      // mode of the running frame
    vga_pixel_pkg::line_addr_t  cur_base;   // frame base of the running frame

    vga_timing_pkg::vga_count_t cnt_h;
    vga_timing_pkg::vga_count_t cnt_v;

    vga_timing_pkg::vga_count_t h_total;
    vga_timing_pkg::vga_count_t v_total;
    vga_timing_pkg::vga_count_t h_sync;
    vga_timing_pkg::vga_count_t v_sync;
    vga_timing_pkg::vga_count_t h_start;
    vga_timing_pkg::vga_count_t v_start;
    vga_timing_pkg::vga_count_t h_end;
    vga_timing_pkg::vga_count_t v_end;

    logic                       frame_start;
    logic                       h_active;
    logic                       v_active;
    logic                       req_window;
    vga_timing_pkg::vga_count_t h_pos;      // position inside the visible part
    vga_pixel_pkg::line_addr_t  disp_line;  // store line of the current row
    vga_pixel_pkg::pixel_t      pixel;

    // limits follow the mode latched at frame start
    always_comb begin
        if (res_q == vga_timing_pkg::res_1024x768) begin
            h_total = vga_timing_pkg::vga_count_t'(`VGA_H1024_TOTAL);
            v_total = vga_timing_pkg::vga_count_t'(`VGA_V768_TOTAL);
            h_sync  = vga_timing_pkg::vga_count_t'(`VGA_H1024_SYNC);
            v_sync  = vga_timing_pkg::vga_count_t'(`VGA_V768_SYNC);
            h_start = vga_timing_pkg::vga_count_t'(`VGA_H1024_SYNC + `VGA_H1024_BACK);
            v_start = vga_timing_pkg::vga_count_t'(`VGA_V768_SYNC + `VGA_V768_BACK);
            h_end   = h_start + vga_timing_pkg::vga_count_t'(`VGA_H1024_DISP);
            v_end   = v_start + vga_timing_pkg::vga_count_t'(`VGA_V768_DISP);
        end else begin
            h_total = vga_timing_pkg::vga_count_t'(`VGA_H640_TOTAL);
            v_total = vga_timing_pkg::vga_count_t'(`VGA_V480_TOTAL);
            h_sync  = vga_timing_pkg::vga_count_t'(`VGA_H640_SYNC);
            v_sync  = vga_timing_pkg::vga_count_t'(`VGA_V480_SYNC);
            h_start = vga_timing_pkg::vga_count_t'(`VGA_H640_SYNC + `VGA_H640_BACK);
            v_start = vga_timing_pkg::vga_count_t'(`VGA_V480_SYNC + `VGA_V480_BACK);
            h_end   = h_start + vga_timing_pkg::vga_count_t'(`VGA_H640_DISP);
            v_end   = v_start + vga_timing_pkg::vga_count_t'(`VGA_V480_DISP);
        end
    end

    assign frame_start = (cnt_h == '0) && (cnt_v == '0);

    assign h_active   = (cnt_h >= h_start) && (cnt_h < h_end);
    assign v_active   = (cnt_v >= v_start) && (cnt_v < v_end);
    // the loader gets one line of lead on the display
    assign req_window = (cnt_v >= v_start - 11'd1) && (cnt_v <= v_end - 11'd2);

    assign h_pos     = cnt_h - h_start;
    assign disp_line = cur_base + vga_pixel_pkg::line_addr_t'(cnt_v)
                     - vga_pixel_pkg::line_addr_t'(v_start);

    assign line.col    = h_pos[9:0];
    assign line.rd_sel = disp_line[0];   // even store lines live in buffer a
    assign pixel       = line.rd_sel ? line.pixel_b : line.pixel_a;

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_h    <= '0;
            cnt_v    <= '0;
            res_q    <= vga_timing_pkg::res_640x480;
            cur_base <= '0;
        end else begin
            if (frame_start) begin
                res_q    <= res;
                cur_base <= frame_base;
            end
            if (cnt_h == h_total - 11'd1) begin
                cnt_h <= '0;
                if (cnt_v == v_total - 11'd1)
                    cnt_v <= '0;
                else
                    cnt_v <= cnt_v + 11'd1;
            end else begin
                cnt_h <= cnt_h + 11'd1;
            end
        end
    end

    // every output is one cycle behind the counters
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vga_hs    <= 1'b0;
            vga_vs    <= 1'b0;
            blanking  <= 1'b0;
            line_req  <= 1'b0;
            line_sel  <= 1'b0;
            line_addr <= '0;
            vga_rgb   <= '0;
        end else begin
            vga_hs    <= cnt_h < h_sync;
            vga_vs    <= cnt_v < v_sync;
            line_req  <= h_active && req_window && !mute;
            line_addr <= disp_line + vga_pixel_pkg::line_addr_t'(1);   // next row
            line_sel  <= ~disp_line[0];
            vga_rgb   <= (h_active && v_active && !mute) ? pixel : '0;

            // loader may run ahead during vertical blank
            if (cnt_v == v_end + 11'd1)
                blanking <= 1'b1;
            else if (cnt_v == v_start - 11'd3)
                blanking <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vga_display_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vga_display_top (
    input  wire                             vga_clk,
    input  wire                             sys_rst_n,
    input  wire vga_timing_pkg::vga_res_t   res,
    input  wire vga_pixel_pkg::line_addr_t  frame_base,
    input  wire                             mute,       // black screen, no requests

    // loader write port into the line buffers
    input  wire                             buf_wr_en,
    input  wire                             buf_wr_sel, // 1 writes buffer b
    input  wire vga_pixel_pkg::col_addr_t   buf_wr_col,
    input  wire vga_pixel_pkg::pixel_t      buf_wr_data,

    output logic                            vga_hs,
    output logic                            vga_vs,
    output logic                            blanking,
    output logic                            line_req,
    output logic                            line_sel,
    output vga_pixel_pkg::line_addr_t       line_addr,
    output vga_pixel_pkg::pixel_t           vga_rgb
);

    vga_line_if line_bus ();

    vga_line_buffer u_line_buffer (
        .vga_clk (vga_clk),
        .wr_en   (buf_wr_en),
        .wr_sel  (buf_wr_sel),
        .wr_col  (buf_wr_col),
        .wr_data (buf_wr_data),
        .line    (line_bus.buffer)
    );

    vga_scan_timer u_scan_timer (
        .vga_clk    (vga_clk),
        .sys_rst_n  (sys_rst_n),
        .res        (res),
        .frame_base (frame_base),
        .mute       (mute),
        .line       (line_bus.scan),
        .vga_hs     (vga_hs),
        .vga_vs     (vga_vs),
        .blanking   (blanking),
        .line_req   (line_req),
        .line_sel   (line_sel),
        .line_addr  (line_addr),
        .vga_rgb    (vga_rgb)
    );

endmodule

`default_nettype wire

// ==== sim/vga_display_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vga_cfg.svh"

module vga_display_properties (
    input wire                              vga_clk,
    input wire                              sys_rst_n,
    input wire                              mute,
    input wire vga_timing_pkg::vga_res_t    res_q,
    input wire vga_timing_pkg::vga_count_t  cnt_h,
    input wire vga_timing_pkg::vga_count_t  cnt_v,
    input wire                              vga_hs,
    input wire                              line_req,
    input wire vga_pixel_pkg::pixel_t       vga_rgb
);

    localparam vga_timing_pkg::vga_count_t h640_first  = 11'(`VGA_H640_SYNC + `VGA_H640_BACK);
    localparam vga_timing_pkg::vga_count_t v480_first  = 11'(`VGA_V480_SYNC + `VGA_V480_BACK);
    localparam vga_timing_pkg::vga_count_t h1024_first = 11'(`VGA_H1024_SYNC + `VGA_H1024_BACK);
    localparam vga_timing_pkg::vga_count_t v768_first  = 11'(`VGA_V768_SYNC + `VGA_V768_BACK);

    logic [7:0] hs_run;     // cycles in a row with hs high
    logic [7:0] hs_limit;
    logic       win_640;    // counters inside the visible 640x480 area
    logic       win_1024;
    logic       in_window;

    assign hs_limit = (res_q == vga_timing_pkg::res_1024x768) ? 8'(`VGA_H1024_SYNC)
                                                              : 8'(`VGA_H640_SYNC);

    assign win_640  = (cnt_h >= h640_first) && (cnt_h < h640_first + 11'(`VGA_H640_DISP))
                   && (cnt_v >= v480_first) && (cnt_v < v480_first + 11'(`VGA_V480_DISP));
    assign win_1024 = (cnt_h >= h1024_first) && (cnt_h < h1024_first + 11'(`VGA_H1024_DISP))
                   && (cnt_v >= v768_first) && (cnt_v < v768_first + 11'(`VGA_V768_DISP));
    assign in_window = (res_q == vga_timing_pkg::res_1024x768) ? win_1024 : win_640;

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            hs_run <= '0;
        else if (vga_hs)
            hs_run <= hs_run + 8'd1;
        else
            hs_run <= '0;
    end

    hs_width: assert property (@(posedge vga_clk) disable iff (!sys_rst_n)
        hs_run <= hs_limit) else $error("hs pulse longer than the sync width");

    // outputs lag the counters by one cycle
    rgb_blank: assert property (@(posedge vga_clk) disable iff (!sys_rst_n)
        !$past(in_window) |-> vga_rgb == '0) else $error("pixel outside window");

    mute_no_req: assert property (@(posedge vga_clk) disable iff (!sys_rst_n)
        $past(mute) |-> !line_req) else $error("line request while muted");

endmodule

`default_nettype wire

// ==== sim/vga_display_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vga_cfg.svh"

module vga_display_tb;

    localparam int clk_period  = 20;
    localparam int frame_640   = clk_period * `VGA_H640_TOTAL * `VGA_V480_TOTAL;
    localparam int frame_1024  = clk_period * `VGA_H1024_TOTAL * `VGA_V768_TOTAL;
    localparam int watchdog_ns = 3 * frame_1024 + 2 * frame_640 + 1000000;
    localparam int h_start     = `VGA_H640_SYNC + `VGA_H640_BACK;
    localparam int h_end       = h_start + `VGA_H640_DISP;
    localparam int v_start     = `VGA_V480_SYNC + `VGA_V480_BACK;
    localparam int v_end       = v_start + `VGA_V480_DISP;
    localparam int moved_base  = 5;

    logic                      vga_clk;
    logic                      sys_rst_n;
    vga_timing_pkg::vga_res_t  res;
    vga_pixel_pkg::line_addr_t frame_base;
    logic                      mute;
    logic                      buf_wr_en;
    logic                      buf_wr_sel;
    vga_pixel_pkg::col_addr_t  buf_wr_col;
    vga_pixel_pkg::pixel_t     buf_wr_data;
    logic                      vga_hs;
    logic                      vga_vs;
    logic                      blanking;
    logic                      line_req;
    logic                      line_sel;
    vga_pixel_pkg::line_addr_t line_addr;
    vga_pixel_pkg::pixel_t     vga_rgb;

    vga_pixel_pkg::pixel_t     model_a [`VGA_LINE_DEPTH];   // loader's copy of buffer a
    vga_pixel_pkg::pixel_t     model_b [`VGA_LINE_DEPTH];
    int                        seed;
    int                        line_no;   // lines since the last vs rise
    int                        pos_no;    // cycles since the last hs rise
    logic                      hs_prev;
    logic                      vs_prev;

    vga_display_top u_vga_display_top (.*);

    bind vga_scan_timer vga_display_properties u_properties (
        .vga_clk(vga_clk), .sys_rst_n(sys_rst_n), .mute(mute), .res_q(res_q),
        .cnt_h(cnt_h), .cnt_v(cnt_v), .vga_hs(vga_hs),
        .line_req(line_req), .vga_rgb(vga_rgb)
    );

    always #(clk_period / 2) vga_clk = ~vga_clk;

    initial begin
        #(watchdog_ns);
        $display("Watchdog: tests did not complete in time, stopped at %0t", $time);
        $display("Finished with errors");
        $fatal(1);
    end

    task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // one falling edge with the position tracked from the sync outputs
    task next_cycle;
        @(negedge vga_clk);
        if (vga_vs && !vs_prev) begin
            line_no = 0;
            pos_no  = 0;
        end else if (vga_hs && !hs_prev) begin
            line_no = line_no + 1;
            pos_no  = 0;
        end else begin
            pos_no = pos_no + 1;
        end
        hs_prev = vga_hs;
        vs_prev = vga_vs;
    endtask

    task wait_position(input int l, input int p);
        while (!(line_no == l && pos_no == p))
            next_cycle();
    endtask

    // runs from the first sample of a pulse up to the first sample of the next one
    task measure_pulse(input logic pick_vs, output int width, output int period);
        width  = 0;
        period = 0;
        while ((pick_vs ? vga_vs : vga_hs) == 1'b1) begin
            width  = width + 1;
            period = period + 1;
            next_cycle();
        end
        while ((pick_vs ? vga_vs : vga_hs) == 1'b0) begin
            period = period + 1;
            next_cycle();
        end
    endtask

    task fill_buffer(input logic sel);
        vga_pixel_pkg::pixel_t data;
        int col;
        for (col = 0; col < `VGA_LINE_DEPTH; col++) begin
            data        = vga_pixel_pkg::pixel_t'($random(seed));
            buf_wr_en   = 1'b1;
            buf_wr_sel  = sel;
            buf_wr_col  = vga_pixel_pkg::col_addr_t'(col);
            buf_wr_data = data;
            if (sel)
                model_b[col] = data;
            else
                model_a[col] = data;
            next_cycle();
        end
        buf_wr_en = 1'b0;
    endtask

    task apply_reset;
        repeat (5) begin
            next_cycle();
            check_value("vga_hs", 32'(vga_hs), 32'd0);
            check_value("vga_vs", 32'(vga_vs), 32'd0);
            check_value("line_req", 32'(line_req), 32'd0);
            check_value("blanking", 32'(blanking), 32'd0);
            check_value("vga_rgb", 32'(vga_rgb), 32'd0);
        end
        sys_rst_n = 1'b1;
        repeat (4) begin
            next_cycle();
            check_value("line_req", 32'(line_req), 32'd0);
            check_value("blanking", 32'(blanking), 32'd0);
            check_value("vga_rgb", 32'(vga_rgb), 32'd0);
        end
    endtask

    task verify_pixels;
        vga_pixel_pkg::pixel_t expected;
        int x;
        int y;
        for (y = 0; y < 4; y++) begin
            wait_position(v_start + y, h_start - 1);
            check_value("vga_rgb", 32'(vga_rgb), 32'd0);
            for (x = 0; x < `VGA_H640_DISP; x++) begin
                next_cycle();
                expected = (y % 2 == 0) ? model_a[x] : model_b[x];   // even rows from a at base 0
                check_value("vga_rgb", 32'(vga_rgb), 32'(expected));
            end
            next_cycle();
            check_value("vga_rgb", 32'(vga_rgb), 32'd0);
        end
    endtask

    task time_sync_outputs(input int h_sync, input int h_total, input int v_sync,
                           input int v_total);
        int width;
        int period;
        wait_position(0, 0);
        measure_pulse(1'b1, width, period);
        check_value("vga_vs width", 32'(width), 32'(v_sync * h_total));
        check_value("vga_vs period", 32'(period), 32'(v_total * h_total));
        measure_pulse(1'b0, width, period);   // frame start is an hs pulse too
        check_value("vga_hs width", 32'(width), 32'(h_sync));
        check_value("vga_hs period", 32'(period), 32'(h_total));
    endtask

    task follow_line_requests;
        int l;
        int expected;
        for (l = v_start - 1; l <= v_end - 4; l++) begin
            expected = moved_base + (l - v_start + 1);   // row shown on the next line
            wait_position(l, h_start - 1);
            check_value("line_req", 32'(line_req), 32'd0);
            next_cycle();
            check_value("line_req", 32'(line_req), 32'd1);
            check_value("line_addr", 32'(line_addr), 32'(expected));
            check_value("line_sel", 32'(line_sel), 32'(expected % 2));
            wait_position(l, h_end - 1);
            check_value("line_req", 32'(line_req), 32'd1);
            next_cycle();
            check_value("line_req", 32'(line_req), 32'd0);
        end
        mute = 1'b1;
        wait_position(v_end - 3, 0);
        repeat (3 * `VGA_H640_TOTAL) begin
            check_value("line_req", 32'(line_req), 32'd0);
            check_value("vga_rgb", 32'(vga_rgb), 32'd0);
            next_cycle();
        end
        mute = 1'b0;
    endtask

    task watch_blanking;
        wait_position(v_end, `VGA_H640_TOTAL - 1);
        check_value("blanking", 32'(blanking), 32'd0);
        next_cycle();
        check_value("blanking", 32'(blanking), 32'd1);
        wait_position(v_start - 4, `VGA_H640_TOTAL - 1);   // next frame
        check_value("blanking", 32'(blanking), 32'd1);
        next_cycle();
        check_value("blanking", 32'(blanking), 32'd0);
    endtask

    task switch_resolution;
        int width;
        int period;
        res = vga_timing_pkg::res_1024x768;   // old geometry holds until the next frame
        wait_position(v_start + 5, 0);
        measure_pulse(1'b0, width, period);
        check_value("vga_hs width", 32'(width), 32'(`VGA_H640_SYNC));
        check_value("vga_hs period", 32'(period), 32'(`VGA_H640_TOTAL));
        time_sync_outputs(`VGA_H1024_SYNC, `VGA_H1024_TOTAL, `VGA_V768_SYNC, `VGA_V768_TOTAL);
    endtask

    initial begin
        vga_clk     = 1'b0;
        sys_rst_n   = 1'b0;
        res         = vga_timing_pkg::res_640x480;
        frame_base  = '0;
        mute        = 1'b0;
        buf_wr_en   = 1'b0;
        buf_wr_sel  = 1'b0;
        buf_wr_col  = '0;
        buf_wr_data = '0;
        seed        = 32'h1cf;
        line_no     = -1;
        pos_no      = 0;
        hs_prev     = 1'b0;
        vs_prev     = 1'b0;

        apply_reset();
        fill_buffer(1'b0);
        fill_buffer(1'b1);
        verify_pixels();
        frame_base = vga_pixel_pkg::line_addr_t'(moved_base);   // taken at next frame start
        time_sync_outputs(`VGA_H640_SYNC, `VGA_H640_TOTAL, `VGA_V480_SYNC, `VGA_V480_TOTAL);
        follow_line_requests();
        watch_blanking();
        switch_resolution();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vga_display_top.f ====
+incdir+hdl
hdl/vga_timing_pkg.sv
hdl/vga_pixel_pkg.sv
hdl/vga_line_if.sv
hdl/vga_line_buffer.sv
hdl/vga_scan_timer.sv
hdl/vga_display_top.sv
sim/vga_display_properties.sv
sim/vga_display_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vga_display_tb
FILELIST  ?= vga_display_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qxF "$(PASS_MSG)" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
